/* hdl/priv_csr_pkg.sv */
package priv_csr_pkg;

  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;

  typedef logic [XLEN-1:0] csr_word_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'b00,
    S_MODE        = 2'b01,
    RESERVED_MODE = 2'b10,
    M_MODE        = 2'b11
  } priv_level_e;

  typedef enum logic [1:0] {
    CSR_READ  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [1:0] {
    DIRECT   = 2'b00,
    VECTORED = 2'b01
  } mtvec_mode_e;

  // Standard RISC-V CSR numbers
  typedef enum logic [CSR_ADDR_W-1:0] {
    MVENDORID     = 12'hF11,
    MARCHID       = 12'hF12,
    MIMPID        = 12'hF13,
    MHARTID       = 12'hF14,
    MSTATUS       = 12'h300,
    MISA          = 12'h301,
    MIE           = 12'h304,
    MTVEC         = 12'h305,
    MCOUNTEREN    = 12'h306,
    MCOUNTINHIBIT = 12'h320,
    MSCRATCH      = 12'h340,
    MEPC          = 12'h341,
    MCAUSE        = 12'h342,
    MTVAL         = 12'h343,
    MIP           = 12'h344,
    MCYCLE        = 12'hB00,
    MINSTRET      = 12'hB02,
    MCYCLEH       = 12'hB80,
    MINSTRETH     = 12'hB82,
    CYCLE         = 12'hC00,
    TIME          = 12'hC01,
    INSTRET       = 12'hC02,
    CYCLEH        = 12'hC80,
    TIMEH         = 12'hC81,
    INSTRETH      = 12'hC82
  } csr_addr_e;

  // mstatus fields
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;
  localparam int MSTATUS_MPRV_BIT = 17;
  localparam int MSTATUS_TW_BIT   = 21;

  // Machine interrupt bits, same layout in mie and mip
  localparam int IRQ_SW_BIT    = 3;
  localparam int IRQ_TIMER_BIT = 7;
  localparam int IRQ_EXT_BIT   = 11;

  localparam int CNT_CY_BIT = 0;
  localparam int CNT_TM_BIT = 1;
  localparam int CNT_IR_BIT = 2;

  // MXL = 1 (RV32), extensions I and U
  localparam csr_word_t MISA_VALUE = 32'h4010_0100;

  localparam csr_word_t MSTATUS_RESET = csr_word_t'(1) << MSTATUS_TW_BIT; // mpp = U_MODE

  // Fields that hold state, everything else reads zero
  localparam csr_word_t MSTATUS_WMASK = (csr_word_t'(1) << MSTATUS_MIE_BIT)
                                      | (csr_word_t'(1) << MSTATUS_MPIE_BIT)
                                      | (csr_word_t'(3) << MSTATUS_MPP_LSB)
                                      | (csr_word_t'(1) << MSTATUS_MPRV_BIT)
                                      | (csr_word_t'(1) << MSTATUS_TW_BIT);

  localparam csr_word_t IRQ_MASK = (csr_word_t'(1) << IRQ_SW_BIT)
                                 | (csr_word_t'(1) << IRQ_TIMER_BIT)
                                 | (csr_word_t'(1) << IRQ_EXT_BIT);

  // tm bit of mcountinhibit is hardwired to zero
  localparam csr_word_t CNT_INHIBIT_MASK = (csr_word_t'(1) << CNT_CY_BIT)
                                         | (csr_word_t'(1) << CNT_IR_BIT);

endpackage

/* hdl/csr_bus_if.sv */
`timescale 1ns/1ps

interface csr_bus_if;

  // Driven by the access controller
  priv_csr_pkg::csr_addr_e   addr;
  priv_csr_pkg::csr_word_t   wdata;  // Already holds the read-modify-write result
  logic                      wen;
  priv_csr_pkg::priv_level_e priv;

  // Driven by the register bank
  priv_csr_pkg::csr_word_t   rdata;
  logic                      hit;    // Address lives in this bank
  logic                      denied; // Lives here but not readable at priv

  modport ctrl (
    output addr, wdata, wen, priv,
    input  rdata, hit, denied
  );

  modport bank (
    input  addr, wdata, wen, priv,
    output rdata, hit, denied
  );

endinterface

/* hdl/csr_access_ctrl.sv */
`timescale 1ns/1ps

module csr_access_ctrl (
  input  logic [priv_csr_pkg::CSR_ADDR_W-1:0] csr_addr,
  input  priv_csr_pkg::csr_op_e               csr_op,
  input  priv_csr_pkg::csr_word_t             csr_operand,
  input  priv_csr_pkg::priv_level_e           curr_priv,
  output priv_csr_pkg::csr_word_t             csr_rdata,
  output logic                                csr_invalid,
  csr_bus_if.ctrl                             mach_bus,
  csr_bus_if.ctrl                             cnt_bus
);

  priv_csr_pkg::csr_addr_e addr_enum;
  priv_csr_pkg::csr_word_t old_val;
  priv_csr_pkg::csr_word_t new_val;
  logic modify;
  logic ro_fault;
  logic priv_fault;
  logic any_hit;
  logic any_denied;

  assign addr_enum = priv_csr_pkg::csr_addr_e'(csr_addr);
  assign modify    = (csr_op != priv_csr_pkg::CSR_READ);

  // Top two address bits of 2'b11 mark a read-only CSR
  assign ro_fault   = modify && (csr_addr[11:10] == 2'b11);
  assign priv_fault = (csr_addr[9:8] > curr_priv);

  // Old value from whichever bank owns the address
  always_comb begin
    if (mach_bus.hit) begin
      old_val = mach_bus.rdata;
    end else if (cnt_bus.hit) begin
      old_val = cnt_bus.rdata;
    end else begin
      old_val = '0;
    end
  end

  always_comb begin
    unique case (csr_op)
      priv_csr_pkg::CSR_WRITE: new_val = csr_operand;
      priv_csr_pkg::CSR_SET:   new_val = old_val | csr_operand;
      priv_csr_pkg::CSR_CLEAR: new_val = old_val & ~csr_operand;
      default:                 new_val = old_val; // Plain read, nothing stored
    endcase
  end

  assign any_hit    = mach_bus.hit | cnt_bus.hit;
  assign any_denied = (mach_bus.hit & mach_bus.denied) | (cnt_bus.hit & cnt_bus.denied);

  assign csr_rdata   = old_val;
  assign csr_invalid = ro_fault | priv_fault | ~any_hit | any_denied;

  // Same request to both banks, each one claims its own addresses
  assign mach_bus.addr  = addr_enum;
  assign mach_bus.wdata = new_val;
  assign mach_bus.wen   = modify & ~ro_fault & ~priv_fault;
  assign mach_bus.priv  = curr_priv;

  assign cnt_bus.addr  = addr_enum;
  assign cnt_bus.wdata = new_val;
  assign cnt_bus.wen   = modify & ~ro_fault & ~priv_fault;
  assign cnt_bus.priv  = curr_priv;

endmodule

/* hdl/csr_machine_regs.sv */
`timescale 1ns/1ps

module csr_machine_regs #(
  parameter int HART_ID = 0
) (
  input  logic                    CLK,
  input  logic                    nRST,
  csr_bus_if.bank                 bus,
  input  logic                    inject_mstatus,
  input  logic                    inject_mepc,
  input  logic                    inject_mcause,
  input  logic                    inject_mtval,
  input  logic                    inject_mip,
  input  priv_csr_pkg::csr_word_t next_mstatus,
  input  priv_csr_pkg::csr_word_t next_mepc,
  input  priv_csr_pkg::csr_word_t next_mcause,
  input  priv_csr_pkg::csr_word_t next_mtval,
  input  priv_csr_pkg::csr_word_t next_mip,
  output priv_csr_pkg::csr_word_t curr_mstatus,
  output priv_csr_pkg::csr_word_t curr_mie,
  output priv_csr_pkg::csr_word_t curr_mip,
  output priv_csr_pkg::csr_word_t curr_mtvec,
  output priv_csr_pkg::csr_word_t curr_mepc,
  output priv_csr_pkg::csr_word_t curr_mcause
);

  priv_csr_pkg::csr_word_t     mstatus_q, mstatus_d;
  priv_csr_pkg::csr_word_t     mie_q, mie_d;
  priv_csr_pkg::csr_word_t     mip_q, mip_d;
  priv_csr_pkg::csr_word_t     mscratch_q, mscratch_d;
  priv_csr_pkg::csr_word_t     mepc_q, mepc_d;
  priv_csr_pkg::csr_word_t     mcause_q, mcause_d;
  priv_csr_pkg::csr_word_t     mtval_q, mtval_d;
  logic [priv_csr_pkg::XLEN-3:0] mtvec_base_q, mtvec_base_d;
  priv_csr_pkg::mtvec_mode_e   mtvec_mode_q, mtvec_mode_d;
  logic                        wr;

  // Drop unsupported fields, S and reserved mpp fall back to user
  function automatic priv_csr_pkg::csr_word_t legal_mstatus(input priv_csr_pkg::csr_word_t v);
    priv_csr_pkg::csr_word_t   res;
    priv_csr_pkg::priv_level_e mpp;
    res = v & priv_csr_pkg::MSTATUS_WMASK;
    mpp = priv_csr_pkg::priv_level_e'(v[priv_csr_pkg::MSTATUS_MPP_LSB +: 2]);
    if (mpp == priv_csr_pkg::S_MODE || mpp == priv_csr_pkg::RESERVED_MODE) begin
      res[priv_csr_pkg::MSTATUS_MPP_LSB +: 2] = priv_csr_pkg::U_MODE;
    end
    return res;
  endfunction

  assign wr = bus.wen & bus.hit;

  always_comb begin
    mstatus_d    = mstatus_q;
    mie_d        = mie_q;
    mip_d        = mip_q;
    mscratch_d   = mscratch_q;
    mepc_d       = mepc_q;
    mcause_d     = mcause_q;
    mtval_d      = mtval_q;
    mtvec_base_d = mtvec_base_q;
    mtvec_mode_d = mtvec_mode_q;

    if (wr) begin
      case (bus.addr)
        priv_csr_pkg::MSTATUS:  mstatus_d = legal_mstatus(bus.wdata);
        priv_csr_pkg::MIE:      mie_d = bus.wdata & priv_csr_pkg::IRQ_MASK;
        priv_csr_pkg::MIP:      mip_d = bus.wdata & priv_csr_pkg::IRQ_MASK;
        priv_csr_pkg::MSCRATCH: mscratch_d = bus.wdata;
        priv_csr_pkg::MEPC:     mepc_d = bus.wdata;
        priv_csr_pkg::MCAUSE:   mcause_d = bus.wdata;
        priv_csr_pkg::MTVAL:    mtval_d = bus.wdata;
        priv_csr_pkg::MTVEC: begin
          mtvec_base_d = bus.wdata[priv_csr_pkg::XLEN-1:2];
          if (bus.wdata[1:0] > priv_csr_pkg::VECTORED) begin
            mtvec_mode_d = priv_csr_pkg::DIRECT; // Reserved modes
          end else begin
            mtvec_mode_d = priv_csr_pkg::mtvec_mode_e'(bus.wdata[1:0]);
          end
        end
        default: ; // misa and info registers ignore writes
      endcase
    end

    // Trap side has priority over the CSR instruction
    if (inject_mstatus) mstatus_d = legal_mstatus(next_mstatus);
    if (inject_mepc)    mepc_d = next_mepc;
    if (inject_mcause)  mcause_d = next_mcause;
    if (inject_mtval)   mtval_d = next_mtval;
    if (inject_mip)     mip_d = next_mip & priv_csr_pkg::IRQ_MASK;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_q    <= priv_csr_pkg::MSTATUS_RESET;
      mie_q        <= '0;
      mip_q        <= '0;
      mscratch_q   <= '0;
      mepc_q       <= '0;
      mcause_q     <= '0;
      mtval_q      <= '0;
      mtvec_base_q <= '0;
      mtvec_mode_q <= priv_csr_pkg::DIRECT;
    end else begin
      mstatus_q    <= mstatus_d;
      mie_q        <= mie_d;
      mip_q        <= mip_d;
      mscratch_q   <= mscratch_d;
      mepc_q       <= mepc_d;
      mcause_q     <= mcause_d;
      mtval_q      <= mtval_d;
      mtvec_base_q <= mtvec_base_d;
      mtvec_mode_q <= mtvec_mode_d;
    end
  end

  // Read side
  always_comb begin
    bus.hit   = 1'b1;
    bus.rdata = '0;
    case (bus.addr)
      priv_csr_pkg::MVENDORID,
      priv_csr_pkg::MARCHID,
      priv_csr_pkg::MIMPID:   bus.rdata = '0; // Not implemented, read zero
      priv_csr_pkg::MHARTID:  bus.rdata = priv_csr_pkg::csr_word_t'(HART_ID);
      priv_csr_pkg::MISA:     bus.rdata = priv_csr_pkg::MISA_VALUE;
      priv_csr_pkg::MSTATUS:  bus.rdata = mstatus_q;
      priv_csr_pkg::MIE:      bus.rdata = mie_q;
      priv_csr_pkg::MIP:      bus.rdata = mip_q;
      priv_csr_pkg::MTVEC:    bus.rdata = {mtvec_base_q, mtvec_mode_q};
      priv_csr_pkg::MSCRATCH: bus.rdata = mscratch_q;
      priv_csr_pkg::MEPC:     bus.rdata = mepc_q;
      priv_csr_pkg::MCAUSE:   bus.rdata = mcause_q;
      priv_csr_pkg::MTVAL:    bus.rdata = mtval_q;
      default:                bus.hit = 1'b0;
    endcase
  end

  assign bus.denied = 1'b0; // Privilege field check in the controller covers this bank

  assign curr_mstatus = mstatus_q;
  assign curr_mie     = mie_q;
  assign curr_mip     = mip_q;
  assign curr_mtvec   = {mtvec_base_q, mtvec_mode_q};
  assign curr_mepc    = mepc_q;
  assign curr_mcause  = mcause_q;

endmodule

/* hdl/csr_counters.sv */
`timescale 1ns/1ps

module csr_counters (
  input  logic        CLK,
  input  logic        nRST,
  input  logic [63:0] mtime,
  input  logic        inst_ret,
  csr_bus_if.bank     bus
);

  logic [63:0]             cycle_q, cycle_d;
  logic [63:0]             instret_q, instret_d;
  priv_csr_pkg::csr_word_t mcounteren_q, mcounteren_d;
  priv_csr_pkg::csr_word_t mcountinhibit_q, mcountinhibit_d;
  logic                    wr;
  logic                    user_mode;

  assign wr        = bus.wen & bus.hit;
  assign user_mode = (bus.priv == priv_csr_pkg::U_MODE);

  always_comb begin
    mcounteren_d    = mcounteren_q;
    mcountinhibit_d = mcountinhibit_q;
    cycle_d         = cycle_q;
    instret_d       = instret_q;

    if (!mcountinhibit_q[priv_csr_pkg::CNT_CY_BIT]) begin
      cycle_d = cycle_q + 64'd1;
    end
    if (!mcountinhibit_q[priv_csr_pkg::CNT_IR_BIT]) begin
      instret_d = instret_q + {63'd0, inst_ret};
    end

    // A half written this cycle replaces the increment
    if (wr) begin
      case (bus.addr)
        priv_csr_pkg::MCOUNTEREN:    mcounteren_d = bus.wdata;
        priv_csr_pkg::MCOUNTINHIBIT: mcountinhibit_d = bus.wdata & priv_csr_pkg::CNT_INHIBIT_MASK;
        priv_csr_pkg::MCYCLE:        cycle_d = {cycle_q[63:32], bus.wdata};
        priv_csr_pkg::MCYCLEH:       cycle_d = {bus.wdata, cycle_q[31:0]};
        priv_csr_pkg::MINSTRET:      instret_d = {instret_q[63:32], bus.wdata};
        priv_csr_pkg::MINSTRETH:     instret_d = {bus.wdata, instret_q[31:0]};
        default: ; // User aliases are read-only
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mcounteren_q    <= '1;
      mcountinhibit_q <= '0;
      cycle_q         <= '0;
      instret_q       <= '0;
    end else begin
      mcounteren_q    <= mcounteren_d;
      mcountinhibit_q <= mcountinhibit_d;
      cycle_q         <= cycle_d;
      instret_q       <= instret_d;
    end
  end

  // Read side, user aliases gated by mcounteren in U_MODE
  always_comb begin
    bus.hit    = 1'b1;
    bus.denied = 1'b0;
    bus.rdata  = '0;
    case (bus.addr)
      priv_csr_pkg::MCOUNTEREN:    bus.rdata = mcounteren_q;
      priv_csr_pkg::MCOUNTINHIBIT: bus.rdata = mcountinhibit_q;
      priv_csr_pkg::MCYCLE:        bus.rdata = cycle_q[31:0];
      priv_csr_pkg::MCYCLEH:       bus.rdata = cycle_q[63:32];
      priv_csr_pkg::MINSTRET:      bus.rdata = instret_q[31:0];
      priv_csr_pkg::MINSTRETH:     bus.rdata = instret_q[63:32];
      priv_csr_pkg::CYCLE,
      priv_csr_pkg::CYCLEH: begin
        bus.denied = user_mode && !mcounteren_q[priv_csr_pkg::CNT_CY_BIT];
        bus.rdata  = bus.addr[7] ? cycle_q[63:32] : cycle_q[31:0];
      end
      priv_csr_pkg::INSTRET,
      priv_csr_pkg::INSTRETH: begin
        bus.denied = user_mode && !mcounteren_q[priv_csr_pkg::CNT_IR_BIT];
        bus.rdata  = bus.addr[7] ? instret_q[63:32] : instret_q[31:0];
      end
      priv_csr_pkg::TIME,
      priv_csr_pkg::TIMEH: begin
        bus.denied = user_mode && !mcounteren_q[priv_csr_pkg::CNT_TM_BIT];
        bus.rdata  = bus.addr[7] ? mtime[63:32] : mtime[31:0]; // Platform timer
      end
      default: bus.hit = 1'b0;
    endcase

    // No data leaks out on a denied read
    if (bus.denied) begin
      bus.rdata = '0;
    end
  end

endmodule

/* hdl/priv_csr_file.sv */
`timescale 1ns/1ps

module priv_csr_file #(
  parameter int HART_ID = 0
) (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic [63:0]                         mtime,
  input  logic                                inst_ret,
  // CSR access from the core
  input  logic [priv_csr_pkg::CSR_ADDR_W-1:0] csr_addr,
  input  priv_csr_pkg::csr_op_e               csr_op,
  input  priv_csr_pkg::csr_word_t             csr_operand,
  input  priv_csr_pkg::priv_level_e           curr_priv,
  output priv_csr_pkg::csr_word_t             csr_rdata,
  output logic                                csr_invalid,
  // Trap side injection
  input  logic                                inject_mstatus,
  input  logic                                inject_mepc,
  input  logic                                inject_mcause,
  input  logic                                inject_mtval,
  input  logic                                inject_mip,
  input  priv_csr_pkg::csr_word_t             next_mstatus,
  input  priv_csr_pkg::csr_word_t             next_mepc,
  input  priv_csr_pkg::csr_word_t             next_mcause,
  input  priv_csr_pkg::csr_word_t             next_mtval,
  input  priv_csr_pkg::csr_word_t             next_mip,
  // Current state for the trap logic
  output priv_csr_pkg::csr_word_t             curr_mstatus,
  output priv_csr_pkg::csr_word_t             curr_mie,
  output priv_csr_pkg::csr_word_t             curr_mip,
  output priv_csr_pkg::csr_word_t             curr_mtvec,
  output priv_csr_pkg::csr_word_t             curr_mepc,
  output priv_csr_pkg::csr_word_t             curr_mcause
);

  csr_bus_if mach_bus ();
  csr_bus_if cnt_bus ();

  csr_access_ctrl u_access_ctrl (
    .csr_addr    (csr_addr),
    .csr_op      (csr_op),
    .csr_operand (csr_operand),
    .curr_priv   (curr_priv),
    .csr_rdata   (csr_rdata),
    .csr_invalid (csr_invalid),
    .mach_bus    (mach_bus.ctrl),
    .cnt_bus     (cnt_bus.ctrl)
  );

  csr_machine_regs #(
    .HART_ID (HART_ID)
  ) u_machine_regs (
    .CLK            (CLK),
    .nRST           (nRST),
    .bus            (mach_bus.bank),
    .inject_mstatus (inject_mstatus),
    .inject_mepc    (inject_mepc),
    .inject_mcause  (inject_mcause),
    .inject_mtval   (inject_mtval),
    .inject_mip     (inject_mip),
    .next_mstatus   (next_mstatus),
    .next_mepc      (next_mepc),
    .next_mcause    (next_mcause),
    .next_mtval     (next_mtval),
    .next_mip       (next_mip),
    .curr_mstatus   (curr_mstatus),
    .curr_mie       (curr_mie),
    .curr_mip       (curr_mip),
    .curr_mtvec     (curr_mtvec),
    .curr_mepc      (curr_mepc),
    .curr_mcause    (curr_mcause)
  );

  csr_counters u_counters (
    .CLK      (CLK),
    .nRST     (nRST),
    .mtime    (mtime),
    .inst_ret (inst_ret),
    .bus      (cnt_bus.bank)
  );

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

/* bench/tb_priv_csr_file.sv */
`timescale 1ns/1ps

module tb_priv_csr_file;

  localparam int PERIOD_NS    = 100;
  localparam int RESET_CYCLES = 10;
  localparam int HART_ID      = 5;
  localparam int RMW_OPS      = 60;
  // About four times what the sequence below needs
  localparam int WATCHDOG_CYCLES = 4 * (RESET_CYCLES + 3 * RMW_OPS + 310);

  localparam priv_csr_pkg::csr_word_t EXP_MISA     = (32'd1 << 30) | (32'd1 << 20) | (32'd1 << 8);
  localparam priv_csr_pkg::csr_word_t MSTATUS_KEEP = 32'h0022_1888; // tw, mprv, mpp, mpie, mie
  localparam priv_csr_pkg::csr_word_t IRQ_KEEP     = 32'h0000_0888; // Bits 11, 7 and 3

  logic                                CLK;
  logic                                nRST;
  logic [63:0]                         mtime;
  logic                                inst_ret;
  logic [priv_csr_pkg::CSR_ADDR_W-1:0] csr_addr;
  priv_csr_pkg::csr_op_e               csr_op;
  priv_csr_pkg::csr_word_t             csr_operand;
  priv_csr_pkg::priv_level_e           curr_priv;
  priv_csr_pkg::csr_word_t             csr_rdata;
  logic                                csr_invalid;
  logic                    inject_mstatus, inject_mepc, inject_mcause, inject_mtval, inject_mip;
  priv_csr_pkg::csr_word_t next_mstatus, next_mepc, next_mcause, next_mtval, next_mip;
  priv_csr_pkg::csr_word_t curr_mstatus, curr_mie, curr_mip, curr_mtvec, curr_mepc, curr_mcause;

  logic [15:0]             lfsr_state;
  priv_csr_pkg::csr_word_t model [3];    // mscratch, mepc, mtval
  logic [11:0]             rmw_addr [3];

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (.*);

  priv_csr_file #(.HART_ID(HART_ID)) DUT (.*);

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic priv_csr_pkg::csr_word_t random_bits(input int nbits);
    priv_csr_pkg::csr_word_t v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic priv_csr_pkg::csr_word_t apply_op(input priv_csr_pkg::csr_op_e op,
      input priv_csr_pkg::csr_word_t old, input priv_csr_pkg::csr_word_t operand);
    case (op)
      priv_csr_pkg::CSR_WRITE: return operand;
      priv_csr_pkg::CSR_SET:   return old | operand;
      priv_csr_pkg::CSR_CLEAR: return old & ~operand;
      default:                 return old;
    endcase
  endfunction

  task automatic check_word(input string name, input priv_csr_pkg::csr_word_t exp,
                            input priv_csr_pkg::csr_word_t act);
    assert (act === exp) else begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      $display("Regression failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // One access per cycle, leaves a plain M_MODE read on the bus
  task automatic csr_access(input logic [11:0] addr, input priv_csr_pkg::csr_op_e op,
                            input priv_csr_pkg::csr_word_t operand,
                            input priv_csr_pkg::priv_level_e priv,
                            output priv_csr_pkg::csr_word_t rdata, output logic invalid);
    csr_addr    = addr;
    csr_op      = op;
    csr_operand = operand;
    curr_priv   = priv;
    #(PERIOD_NS / 4);
    rdata   = csr_rdata;
    invalid = csr_invalid;
    @(negedge CLK);
    csr_op    = priv_csr_pkg::CSR_READ;
    curr_priv = priv_csr_pkg::M_MODE;
  endtask

  task automatic expect_read(input logic [11:0] addr, input priv_csr_pkg::priv_level_e priv,
                             input priv_csr_pkg::csr_word_t exp, input string name);
    priv_csr_pkg::csr_word_t rdata;
    logic                    invalid;
    csr_access(addr, priv_csr_pkg::CSR_READ, '0, priv, rdata, invalid);
    check_word({"csr_invalid on ", name}, 32'd0, invalid);
    check_word({"csr_rdata of ", name}, exp, rdata);
  endtask

  task automatic modify_csr(input logic [11:0] addr, input priv_csr_pkg::csr_op_e op,
                            input priv_csr_pkg::csr_word_t operand);
    priv_csr_pkg::csr_word_t rdata;
    logic                    invalid;
    csr_access(addr, op, operand, priv_csr_pkg::M_MODE, rdata, invalid);
    check_word("csr_invalid on machine write", 32'd0, invalid);
  endtask

  task automatic expect_invalid(input logic [11:0] addr, input priv_csr_pkg::csr_op_e op,
                                input priv_csr_pkg::csr_word_t operand,
                                input priv_csr_pkg::priv_level_e priv, input string name);
    priv_csr_pkg::csr_word_t rdata;
    logic                    invalid;
    csr_access(addr, op, operand, priv, rdata, invalid);
    check_word({"csr_invalid on ", name}, 32'd1, invalid);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    priv_csr_pkg::csr_word_t rdata;
    priv_csr_pkg::csr_word_t w;
    priv_csr_pkg::csr_word_t exp;
    priv_csr_pkg::csr_op_e   op;
    logic                    invalid;
    int                      idx;
    int                      cnt;
    time                     t1;

    lfsr_state     = 16'd63719;
    mtime          = '0;
    inst_ret       = 1'b0;
    csr_addr       = priv_csr_pkg::MSTATUS;
    csr_op         = priv_csr_pkg::CSR_READ;
    csr_operand    = '0;
    curr_priv      = priv_csr_pkg::M_MODE;
    inject_mstatus = 1'b0;
    inject_mepc    = 1'b0;
    inject_mcause  = 1'b0;
    inject_mtval   = 1'b0;
    inject_mip     = 1'b0;
    next_mstatus   = '0;
    next_mepc      = '0;
    next_mcause    = '0;
    next_mtval     = '0;
    next_mip       = '0;
    rmw_addr[0]    = priv_csr_pkg::MSCRATCH;
    rmw_addr[1]    = priv_csr_pkg::MEPC;
    rmw_addr[2]    = priv_csr_pkg::MTVAL;
    for (int i = 0; i < 3; i++) model[i] = '0;
    @(posedge nRST);
    @(negedge CLK);

    // Reset values
    expect_read(priv_csr_pkg::MSTATUS, priv_csr_pkg::M_MODE, 32'h0020_0000, "mstatus");
    expect_read(priv_csr_pkg::MHARTID, priv_csr_pkg::M_MODE, HART_ID, "mhartid");
    expect_read(priv_csr_pkg::MISA, priv_csr_pkg::M_MODE, EXP_MISA, "misa");
    expect_read(priv_csr_pkg::MTVEC, priv_csr_pkg::M_MODE, '0, "mtvec");
    expect_read(priv_csr_pkg::MIE, priv_csr_pkg::M_MODE, '0, "mie");
    expect_read(priv_csr_pkg::MSCRATCH, priv_csr_pkg::M_MODE, '0, "mscratch");
    expect_read(priv_csr_pkg::MCOUNTEREN, priv_csr_pkg::M_MODE, '1, "mcounteren");

    // Random read-modify-write traffic, old value comes back in the same cycle
    for (int i = 0; i < RMW_OPS; i++) begin
      w       = random_bits(2);
      idx     = w % 3;
      w       = random_bits(2);
      op      = priv_csr_pkg::csr_op_e'(w[1:0]);
      exp     = random_bits(32);
      csr_access(rmw_addr[idx], op, exp, priv_csr_pkg::M_MODE, rdata, invalid);
      check_word("csr_invalid on rmw", 32'd0, invalid);
      check_word("csr_rdata on rmw", model[idx], rdata);
      model[idx] = apply_op(op, model[idx], exp);
    end
    for (int i = 0; i < 3; i++) expect_read(rmw_addr[i], priv_csr_pkg::M_MODE, model[i], "rmw");

    // mpp of S or reserved falls back to U
    for (int mpp = 1; mpp < 4; mpp++) begin
      w        = random_bits(32);
      w[12:11] = mpp[1:0];
      exp      = w & MSTATUS_KEEP;
      if (mpp != 3) exp[12:11] = 2'b00;
      modify_csr(priv_csr_pkg::MSTATUS, priv_csr_pkg::CSR_WRITE, w);
      expect_read(priv_csr_pkg::MSTATUS, priv_csr_pkg::M_MODE, exp, "mstatus");
      check_word("curr_mstatus", exp, curr_mstatus);
    end
    for (int mode = 0; mode < 4; mode++) begin
      w      = random_bits(32);
      w[1:0] = mode[1:0];
      exp    = (mode < 2) ? w : {w[31:2], 2'b00};
      modify_csr(priv_csr_pkg::MTVEC, priv_csr_pkg::CSR_WRITE, w);
      expect_read(priv_csr_pkg::MTVEC, priv_csr_pkg::M_MODE, exp, "mtvec");
      check_word("curr_mtvec", exp, curr_mtvec);
    end
    w = random_bits(32);
    modify_csr(priv_csr_pkg::MIE, priv_csr_pkg::CSR_WRITE, w);
    expect_read(priv_csr_pkg::MIE, priv_csr_pkg::M_MODE, w & IRQ_KEEP, "mie");
    check_word("curr_mie", w & IRQ_KEEP, curr_mie);
    w = random_bits(32);
    modify_csr(priv_csr_pkg::MIP, priv_csr_pkg::CSR_WRITE, w);
    expect_read(priv_csr_pkg::MIP, priv_csr_pkg::M_MODE, w & IRQ_KEEP, "mip");
    check_word("curr_mip", w & IRQ_KEEP, curr_mip);

    // Rejected accesses must not touch state
    w = random_bits(32);
    expect_invalid(priv_csr_pkg::MSCRATCH, priv_csr_pkg::CSR_READ, '0, priv_csr_pkg::U_MODE,
                   "user read of mscratch");
    expect_invalid(priv_csr_pkg::MSCRATCH, priv_csr_pkg::CSR_WRITE, w, priv_csr_pkg::U_MODE,
                   "user write of mscratch");
    expect_read(priv_csr_pkg::MSCRATCH, priv_csr_pkg::M_MODE, model[0], "mscratch");
    expect_invalid(priv_csr_pkg::MHARTID, priv_csr_pkg::CSR_WRITE, w, priv_csr_pkg::M_MODE,
                   "write of mhartid");
    expect_read(priv_csr_pkg::MHARTID, priv_csr_pkg::M_MODE, HART_ID, "mhartid");
    expect_invalid(12'h345, priv_csr_pkg::CSR_WRITE, w, priv_csr_pkg::M_MODE, "unmapped write");
    expect_invalid(12'h345, priv_csr_pkg::CSR_READ, '0, priv_csr_pkg::M_MODE, "unmapped read");
    for (int i = 0; i < 3; i++) expect_read(rmw_addr[i], priv_csr_pkg::M_MODE, model[i], "rmw");

    // mcycle counts one per rising edge between the two samples
    csr_access(priv_csr_pkg::MCYCLE, priv_csr_pkg::CSR_READ, '0, priv_csr_pkg::M_MODE,
               rdata, invalid);
    t1  = $time;
    w   = rdata;
    cnt = 1 + random_bits(4);
    repeat (cnt) @(negedge CLK);
    csr_access(priv_csr_pkg::MCYCLE, priv_csr_pkg::CSR_READ, '0, priv_csr_pkg::M_MODE,
               rdata, invalid);
    check_word("mcycle delta", (32'($time - t1)) / PERIOD_NS, rdata - w);

    modify_csr(priv_csr_pkg::MCOUNTINHIBIT, priv_csr_pkg::CSR_WRITE, 32'h1); // cy only
    csr_access(priv_csr_pkg::MCYCLE, priv_csr_pkg::CSR_READ, '0, priv_csr_pkg::M_MODE,
               rdata, invalid);
    repeat (5) @(negedge CLK);
    expect_read(priv_csr_pkg::MCYCLE, priv_csr_pkg::M_MODE, rdata, "inhibited mcycle");
    modify_csr(priv_csr_pkg::MCOUNTINHIBIT, priv_csr_pkg::CSR_WRITE, '0);

    csr_access(priv_csr_pkg::MINSTRET, priv_csr_pkg::CSR_READ, '0, priv_csr_pkg::M_MODE,
               rdata, invalid);
    cnt = 0;
    for (int i = 0; i < 20; i++) begin
      w        = random_bits(1);
      inst_ret = w[0];
      cnt      = cnt + w[0];
      @(negedge CLK);
    end
    inst_ret = 1'b0;
    expect_read(priv_csr_pkg::MINSTRET, priv_csr_pkg::M_MODE, rdata + cnt, "minstret");

    w = random_bits(32);
    modify_csr(priv_csr_pkg::MCYCLEH, priv_csr_pkg::CSR_WRITE, w);
    expect_read(priv_csr_pkg::MCYCLEH, priv_csr_pkg::M_MODE, w, "mcycleh");

    mtime = {random_bits(32), random_bits(32)};
    expect_read(priv_csr_pkg::TIME, priv_csr_pkg::M_MODE, mtime[31:0], "time");
    expect_read(priv_csr_pkg::TIMEH, priv_csr_pkg::U_MODE, mtime[63:32], "timeh");

    // User cycle access follows mcounteren bit 0
    csr_access(priv_csr_pkg::CYCLE, priv_csr_pkg::CSR_READ, '0, priv_csr_pkg::U_MODE,
               rdata, invalid);
    check_word("csr_invalid on user cycle read", 32'd0, invalid);
    modify_csr(priv_csr_pkg::MCOUNTEREN, priv_csr_pkg::CSR_CLEAR, 32'h1);
    expect_read(priv_csr_pkg::MCOUNTEREN, priv_csr_pkg::M_MODE, 32'hFFFF_FFFE, "mcounteren");
    expect_invalid(priv_csr_pkg::CYCLE, priv_csr_pkg::CSR_READ, '0, priv_csr_pkg::U_MODE,
                   "user cycle read");

    // mcause from a CSR write, then from the trap side
    w = random_bits(32);
    modify_csr(priv_csr_pkg::MCAUSE, priv_csr_pkg::CSR_WRITE, w);
    check_word("curr_mcause", w, curr_mcause);
    w             = random_bits(32);
    inject_mcause = 1'b1;
    next_mcause   = w;
    @(negedge CLK);
    inject_mcause = 1'b0;
    check_word("curr_mcause", w, curr_mcause);
    expect_read(priv_csr_pkg::MCAUSE, priv_csr_pkg::M_MODE, w, "mcause");

    // Trap injection beats a CSR write in the same cycle
    w           = random_bits(32);
    exp         = random_bits(32);
    inject_mepc = 1'b1;
    next_mepc   = exp;
    modify_csr(priv_csr_pkg::MEPC, priv_csr_pkg::CSR_WRITE, w);
    inject_mepc = 1'b0;
    check_word("curr_mepc", exp, curr_mepc);
    expect_read(priv_csr_pkg::MEPC, priv_csr_pkg::M_MODE, exp, "mepc");

    $display("Regression passed");
    $finish;
  end

endmodule

/* priv_csr.f */
hdl/priv_csr_pkg.sv
hdl/csr_bus_if.sv
hdl/csr_access_ctrl.sv
hdl/csr_machine_regs.sv
hdl/csr_counters.sv
hdl/priv_csr_file.sv
bench/tb_clock_gen.sv
bench/tb_priv_csr_file.sv

/* Bender.yml */
package:
  name: priv_csr

sources:
  - files:
      - hdl/priv_csr_pkg.sv
      - hdl/csr_bus_if.sv
      - hdl/csr_access_ctrl.sv
      - hdl/csr_machine_regs.sv
      - hdl/csr_counters.sv
      - hdl/priv_csr_file.sv
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_priv_csr_file.sv
